// ==== project.f ====
+incdir+tb
hdl/z80fi_pkg.sv
hdl/z80fi_insn_spec_shift_idx_ixiy.sv
hdl/z80fi_insn_spec_rot_idx_ixiy.sv
hdl/z80fi_insn_spec_bit_idx_ixiy.sv
hdl/z80fi_spec_select.sv
hdl/z80fi_insn_check.sv
hdl/z80fi_idx_cb_checker.sv
tb/tb_z80fi_idx_cb_checker.sv

// ==== tb/tb_z80fi_ref.svh ====
// Reference model for the indexed CB group testbench.
// Expected spec of one trace entry, and the LFSR behind the stimulus.
`ifndef TB_Z80FI_REF_SVH
`define TB_Z80FI_REF_SVH

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic void ref_spec(
    input  logic [31:0] insn,
    input  logic [2:0]  len,
    input  logic [15:0] ip, ix, iy,
    input  logic [7:0]  f, rd,
    output logic        known,
    output logic [3:0]  sig,
    output logic [15:0] addr, ip_out,
    output logic [7:0]  wdata, f_out
);
    logic [7:0] op, pfx, res;
    logic       c, t;
    op     = insn[31:24];
    pfx    = insn[7:0];
    known  = len == 3'd4 && insn[15:8] == 8'hCB && (pfx == 8'hDD || pfx == 8'hFD) &&
             op[2:0] == 3'b110 && op != 8'h36; // 0x36 is SLL.
    addr   = (pfx[5] ? iy : ix) + {{8{insn[23]}}, insn[23:16]};
    ip_out = ip + 16'd4;
    sig    = 4'b0000;
    wdata  = 8'h00;
    f_out  = f; // F unchanged unless defined below.
    t      = rd[op[5:3]];
    if (known && op[7:6] == 2'b00) begin
        case (op[5:3])
            3'd0: {c, res} = {rd[7], rd[6:0], rd[7]}; // RLC.
            3'd1: {c, res} = {rd[0], rd[0], rd[7:1]}; // RRC.
            3'd2: {c, res} = {rd[7], rd[6:0], f[0]};
            3'd3: {c, res} = {rd[0], f[0], rd[7:1]};
            3'd4: {c, res} = {rd[7], rd[6:0], 1'b0}; // SLA.
            3'd5: {c, res} = {rd[0], rd[7], rd[7:1]}; // SRA.
            default: {c, res} = {rd[0], 1'b0, rd[7:1]}; // SRL.
        endcase
        sig   = 4'b1111; // IP, F, read and write.
        wdata = res;
        f_out = {res[7], res == 8'h00, f[5], 1'b0, f[3], ~^res, 1'b0, c};
    end else if (known && op[7:6] == 2'b01) begin
        sig   = 4'b0111; // BIT reads only.
        f_out = {op[5:3] == 3'd7 && t, !t, addr[13], 1'b1, addr[11], !t, 1'b0, f[0]};
    end else if (known) begin
        sig   = 4'b1101;
        wdata = op[6] ? (rd | (8'h01 << op[5:3])) : (rd & ~(8'h01 << op[5:3]));
    end
endfunction

`endif

// ==== tb/tb_z80fi_idx_cb_checker.sv ====
// Testbench for the Z80 indexed CB group checker.
// Legal and illegal trace entries, with correct and faulted CPU results.

`timescale 1ns/1ps
`default_nettype none

module tb_z80fi_idx_cb_checker;
    import z80fi_pkg::*;

    `include "tb_z80fi_ref.svh"

    localparam int n_legal   = 40;
    localparam int n_fault   = 24;
    localparam int n_unknown = 16;
    localparam int n_b2b     = 48;
    localparam int n_cycles  = 4 + 5 + 2 * (n_legal + n_fault + n_unknown) + n_b2b + 12;

    logic        clock, reset, z80fi_valid, z80fi_mem_rd, z80fi_mem_wr;
    logic [31:0] z80fi_insn;
    logic [2:0]  z80fi_insn_len;
    logic [15:0] z80fi_reg_ip_in, z80fi_reg_ix_in, z80fi_reg_iy_in, z80fi_reg_ip_out;
    logic [7:0]  z80fi_reg_f_in, z80fi_mem_rdata, z80fi_reg_f_out, z80fi_mem_wdata;
    logic [15:0] z80fi_mem_raddr, z80fi_mem_waddr;
    logic        check_valid, check_ok, check_unknown, check_conflict;
    logic [5:0]  mismatch;
    logic [err_count_width-1:0] error_count;

    logic [15:0] lfsr_state = 16'd43269;
    int          faults = 0; // Entries that must raise the error count.
    logic        addr_fault_wr = 1'b0; // Alternates read and write address faults.
    logic        exp_ok_q[$], exp_unknown_q[$];
    logic [5:0]  exp_mis_q[$];

    z80fi_idx_cb_checker dut (.*);

    initial clock = 1'b0;
    always #4 clock = ~clock;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Run stopped.");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH at %0t ns: %s is %b, expected %b",
                $time, name, got, exp));
    endtask

    task automatic check_mismatch(input logic [5:0] got, input logic [5:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH at %0t ns: mismatch is %b, expected %b",
                $time, got, exp));
    endtask

    task automatic check_count(input logic [err_count_width-1:0] got,
                               input logic [err_count_width-1:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH at %0t ns: error_count is %0d, expected %0d",
                $time, got, exp));
    endtask

    // One LFSR step per bit taken.
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [31:0] legal_insn(input int fault);
        logic [1:0] grp;
        logic [2:0] k;
        logic [7:0] d;
        logic       iy;
        grp = 2'(take_bits(2));
        k   = 3'(take_bits(3));
        d   = 8'(take_bits(8));
        iy  = 1'(take_bits(1));
        if (fault == mis_wdata)
            grp = 2'b11; // Needs an instruction that writes.
        if (fault == mis_addr)
            grp[1] = 1'b1; // SET or RES, so both addresses count.
        if (grp == 2'b00 && k == 3'd6)
            k = 3'd4; // Not SLL.
        return {grp, k, 3'b110, d, 8'hCB, iy ? 8'hFD : 8'hDD};
    endfunction

    task automatic send(input logic [31:0] insn, input logic [2:0] len, input int fault);
        logic        known;
        logic [3:0]  sig;
        logic [15:0] addr, ip_exp;
        logic [7:0]  wdata, f_exp;
        logic [5:0]  mis;
        @(negedge clock);
        z80fi_valid     = 1'b1;
        z80fi_insn      = insn;
        z80fi_insn_len  = len;
        z80fi_reg_ip_in = take_bits(16);
        z80fi_reg_ix_in = take_bits(16);
        z80fi_reg_iy_in = take_bits(16);
        z80fi_reg_f_in  = 8'(take_bits(8));
        z80fi_mem_rdata = 8'(take_bits(8));
        ref_spec(insn, len, z80fi_reg_ip_in, z80fi_reg_ix_in, z80fi_reg_iy_in, z80fi_reg_f_in,
            z80fi_mem_rdata, known, sig, addr, ip_exp, wdata, f_exp);
        z80fi_reg_ip_out = ip_exp; // A correct CPU first.
        z80fi_reg_f_out  = f_exp;
        z80fi_mem_rd     = sig[spec_mem_rd];
        z80fi_mem_wr     = sig[spec_mem_wr];
        z80fi_mem_raddr  = addr;
        z80fi_mem_waddr  = sig[spec_mem_wr] ? addr : take_bits(16); // Don't care on BIT.
        z80fi_mem_wdata  = sig[spec_mem_wr] ? wdata : 8'(take_bits(8));
        mis = 6'b0;
        case (fault)
            mis_ip:    z80fi_reg_ip_out ^= 16'h1 << take_bits(4);
            mis_f:     z80fi_reg_f_out ^= 8'h1 << take_bits(3);
            mis_rd:    z80fi_mem_rd = !z80fi_mem_rd;
            mis_wr:    z80fi_mem_wr = !z80fi_mem_wr;
            mis_addr: begin
                if (addr_fault_wr)
                    z80fi_mem_waddr ^= 16'h1 << take_bits(4);
                else
                    z80fi_mem_raddr ^= 16'h1 << take_bits(4);
                addr_fault_wr = !addr_fault_wr;
            end
            mis_wdata: z80fi_mem_wdata ^= 8'h1 << take_bits(3);
            default: ;
        endcase
        if (!known) begin
            {z80fi_mem_rd, z80fi_mem_wr} = 2'(take_bits(2)); // Unclaimed ops may do anything.
            z80fi_reg_f_out = 8'(take_bits(8));
        end
        if (known && fault >= 0)
            mis[fault] = 1'b1;
        exp_ok_q.push_back(known && mis == 6'b0);
        exp_unknown_q.push_back(!known);
        exp_mis_q.push_back(mis);
        if (!known || fault >= 0)
            faults++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clock);
            z80fi_valid = 1'b0;
        end
    endtask

    // Results land on the edge that samples the strobe; read them half a cycle later.
    initial begin : compare_results
        logic                       seen, e_ok, e_unk;
        logic [5:0]                 e_mis;
        logic [err_count_width-1:0] e_count;
        e_count = '0;
        forever begin
            @(posedge clock);
            seen = z80fi_valid && reset === 1'b0; // Reset wins over a strobe.
            @(negedge clock);
            {e_ok, e_unk, e_mis} = '0;
            if (seen && exp_ok_q.size() == 0)
                stop_with_failure("A strobe was seen with no expected result queued.");
            if (seen) begin
                e_ok  = exp_ok_q.pop_front();
                e_unk = exp_unknown_q.pop_front();
                e_mis = exp_mis_q.pop_front();
            end
            if (seen && !e_ok && e_count != '1)
                e_count++;
            check_flag("check_valid", check_valid, seen);
            check_flag("check_ok", check_ok, e_ok);
            check_flag("check_unknown", check_unknown, e_unk);
            check_flag("check_conflict", check_conflict, 1'b0);
            check_mismatch(mismatch, e_mis);
            check_count(error_count, e_count);
        end
    end

    initial begin : watchdog
        #(n_cycles * 8 * 2);
        stop_with_failure("Timeout: the test did not finish in the expected time.");
    end

    initial begin : stimulus
        logic [31:0] insn;
        logic [2:0]  len, k;
        int          fault;
        reset = 1'b1;
        {z80fi_valid, z80fi_insn, z80fi_insn_len, z80fi_reg_ip_in, z80fi_reg_ix_in,
         z80fi_reg_iy_in, z80fi_reg_f_in, z80fi_mem_rdata, z80fi_reg_ip_out, z80fi_reg_f_out,
         z80fi_mem_rd, z80fi_mem_wr, z80fi_mem_raddr, z80fi_mem_waddr, z80fi_mem_wdata} = '0;
        z80fi_valid = 1'b1; // A strobe during reset must leave no trace.
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset       = 1'b0;
        z80fi_valid = 1'b0;
        idle(5);
        for (int i = 0; i < n_legal; i++) begin
            send(legal_insn(-1), insn_len_idx_cb, -1);
            idle(1);
        end
        for (int i = 0; i < n_fault; i++) begin
            send(legal_insn(i % 6), insn_len_idx_cb, i % 6);
            idle(1);
        end
        for (int i = 0; i < n_unknown; i++) begin
            insn = legal_insn(-1);
            len  = insn_len_idx_cb;
            case (i % 4)
                0: insn[31:24] = 8'h36; // SLL.
                1: begin
                    len = 3'(take_bits(3));
                    if (len == insn_len_idx_cb)
                        len = 3'd2;
                end
                2: insn[15:8] = insn[15:8] ^ (8'h01 << take_bits(3));
                default: begin
                    k = 3'(take_bits(3));
                    insn[k == 3'd5 ? 0 : k] = !insn[k == 3'd5 ? 0 : k]; // Bit 5 is IX/IY.
                end
            endcase
            send(insn, len, -1);
            idle(1);
        end
        for (int i = 0; i < n_b2b; i++) begin
            fault = take_bits(3);
            if (fault > 5 || take_bits(1))
                fault = -1;
            send(legal_insn(fault), insn_len_idx_cb, fault);
        end
        idle(4);
        while (exp_ok_q.size() != 0)
            @(negedge clock);
        @(negedge clock);
        if (error_count === faults[err_count_width-1:0]) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_with_failure($sformatf("MISMATCH at %0t ns: error_count %0d, faults %0d",
                $time, error_count, faults));
        end
    end

endmodule

`default_nettype wire

// ==== hdl/z80fi_idx_cb_checker.sv ====
// Z80 indexed CB group checker, top level.
// Three spec units feed the selector, whose result the checker compares
// against the CPU trace.

`timescale 1ns/1ps
`default_nettype none

module z80fi_idx_cb_checker (
    input  logic        clock,
    input  logic        reset,
    input  logic        z80fi_valid,
    input  logic [31:0] z80fi_insn,
    input  logic [2:0]  z80fi_insn_len,
    input  logic [15:0] z80fi_reg_ip_in,
    input  logic [15:0] z80fi_reg_ix_in,
    input  logic [15:0] z80fi_reg_iy_in,
    input  logic [7:0]  z80fi_reg_f_in,
    input  logic [7:0]  z80fi_mem_rdata,
    input  logic [15:0] z80fi_reg_ip_out,
    input  logic [7:0]  z80fi_reg_f_out,
    input  logic        z80fi_mem_rd,
    input  logic        z80fi_mem_wr,
    input  logic [15:0] z80fi_mem_raddr,
    input  logic [15:0] z80fi_mem_waddr,
    input  logic [7:0]  z80fi_mem_wdata,
    output logic        check_valid,
    output logic        check_ok,
    output logic        check_unknown,
    output logic        check_conflict,
    output logic [5:0]  mismatch,
    output logic [z80fi_pkg::err_count_width-1:0] error_count
);

    logic        shift_valid, rot_valid, bit_valid, sel_valid, sel_conflict;
    logic [3:0]  shift_signals, rot_signals, bit_signals, sel_signals;
    logic [15:0] shift_mem_raddr, rot_mem_raddr, bit_mem_raddr, sel_mem_raddr;
    logic [15:0] shift_mem_waddr, rot_mem_waddr, bit_mem_waddr, sel_mem_waddr;
    logic [7:0]  shift_mem_wdata, rot_mem_wdata, bit_mem_wdata, sel_mem_wdata;
    logic [7:0]  shift_reg_f_out, rot_reg_f_out, bit_reg_f_out, sel_reg_f_out;
    logic [15:0] shift_reg_ip_out, rot_reg_ip_out, bit_reg_ip_out, sel_reg_ip_out;

    z80fi_insn_spec_shift_idx_ixiy u_shift (
        .z80fi_valid, .z80fi_insn, .z80fi_insn_len, .z80fi_reg_ip_in, .z80fi_reg_f_in,
        .z80fi_reg_ix_in, .z80fi_reg_iy_in, .z80fi_mem_rdata,
        .spec_valid(shift_valid), .spec_signals(shift_signals),
        .spec_mem_raddr(shift_mem_raddr), .spec_mem_waddr(shift_mem_waddr),
        .spec_mem_wdata(shift_mem_wdata), .spec_reg_f_out(shift_reg_f_out),
        .spec_reg_ip_out(shift_reg_ip_out)
    );

    z80fi_insn_spec_rot_idx_ixiy u_rot (
        .z80fi_valid, .z80fi_insn, .z80fi_insn_len, .z80fi_reg_ip_in, .z80fi_reg_f_in,
        .z80fi_reg_ix_in, .z80fi_reg_iy_in, .z80fi_mem_rdata,
        .spec_valid(rot_valid), .spec_signals(rot_signals),
        .spec_mem_raddr(rot_mem_raddr), .spec_mem_waddr(rot_mem_waddr),
        .spec_mem_wdata(rot_mem_wdata), .spec_reg_f_out(rot_reg_f_out),
        .spec_reg_ip_out(rot_reg_ip_out)
    );

    z80fi_insn_spec_bit_idx_ixiy u_bit (
        .z80fi_valid, .z80fi_insn, .z80fi_insn_len, .z80fi_reg_ip_in, .z80fi_reg_f_in,
        .z80fi_reg_ix_in, .z80fi_reg_iy_in, .z80fi_mem_rdata,
        .spec_valid(bit_valid), .spec_signals(bit_signals),
        .spec_mem_raddr(bit_mem_raddr), .spec_mem_waddr(bit_mem_waddr),
        .spec_mem_wdata(bit_mem_wdata), .spec_reg_f_out(bit_reg_f_out),
        .spec_reg_ip_out(bit_reg_ip_out)
    );

    z80fi_spec_select u_select (
        .shift_valid, .rot_valid, .bit_valid,
        .shift_signals, .rot_signals, .bit_signals,
        .shift_mem_raddr, .rot_mem_raddr, .bit_mem_raddr,
        .shift_mem_waddr, .rot_mem_waddr, .bit_mem_waddr,
        .shift_mem_wdata, .rot_mem_wdata, .bit_mem_wdata,
        .shift_reg_f_out, .rot_reg_f_out, .bit_reg_f_out,
        .shift_reg_ip_out, .rot_reg_ip_out, .bit_reg_ip_out,
        .sel_valid, .sel_conflict, .sel_signals, .sel_mem_raddr, .sel_mem_waddr,
        .sel_mem_wdata, .sel_reg_f_out, .sel_reg_ip_out
    );

    z80fi_insn_check u_check (
        .clock, .reset, .z80fi_valid, .z80fi_reg_f_in,
        .z80fi_reg_ip_out, .z80fi_reg_f_out, .z80fi_mem_rd, .z80fi_mem_wr,
        .z80fi_mem_raddr, .z80fi_mem_waddr, .z80fi_mem_wdata,
        .sel_valid, .sel_conflict, .sel_signals, .sel_mem_raddr, .sel_mem_waddr,
        .sel_mem_wdata, .sel_reg_f_out, .sel_reg_ip_out,
        .check_valid, .check_ok, .check_unknown, .check_conflict, .mismatch, .error_count
    );

endmodule

`default_nettype wire

// ==== hdl/z80fi_insn_check.sv ====
// Instruction result checker.
// Compares CPU results with the selected spec and registers the verdict,
// per-field mismatch flags and a saturating error count.

`timescale 1ns/1ps
`default_nettype none

module z80fi_insn_check (
    input  logic        clock,
    input  logic        reset,
    input  logic        z80fi_valid,
    input  logic [7:0]  z80fi_reg_f_in,
    input  logic [15:0] z80fi_reg_ip_out,
    input  logic [7:0]  z80fi_reg_f_out,
    input  logic        z80fi_mem_rd,
    input  logic        z80fi_mem_wr,
    input  logic [15:0] z80fi_mem_raddr,
    input  logic [15:0] z80fi_mem_waddr,
    input  logic [7:0]  z80fi_mem_wdata,
    input  logic        sel_valid,
    input  logic        sel_conflict,
    input  logic [3:0]  sel_signals,
    input  logic [15:0] sel_mem_raddr,
    input  logic [15:0] sel_mem_waddr,
    input  logic [7:0]  sel_mem_wdata,
    input  logic [7:0]  sel_reg_f_out,
    input  logic [15:0] sel_reg_ip_out,
    output logic        check_valid,
    output logic        check_ok,
    output logic        check_unknown,
    output logic        check_conflict,
    output logic [5:0]  mismatch,
    output logic [z80fi_pkg::err_count_width-1:0] error_count
);
    import z80fi_pkg::*;

    logic [5:0] mis_now;
    logic       want_rd, want_wr, unknown, fail;

    assign want_rd = sel_signals[spec_mem_rd];
    assign want_wr = sel_signals[spec_mem_wr];
    assign unknown = !sel_valid && !sel_conflict; // Nothing claimed it.

    // Field compare, only meaningful with exactly one spec.
    always_comb begin
        mis_now            = 6'b0;
        mis_now[mis_ip]    = sel_signals[spec_reg_ip] && z80fi_reg_ip_out != sel_reg_ip_out;
        mis_now[mis_f]     = sel_signals[spec_reg_f] ? z80fi_reg_f_out != sel_reg_f_out :
                                                       z80fi_reg_f_out != z80fi_reg_f_in;
        mis_now[mis_rd]    = z80fi_mem_rd != want_rd;
        mis_now[mis_wr]    = z80fi_mem_wr != want_wr;
        mis_now[mis_addr]  = (want_rd && z80fi_mem_raddr != sel_mem_raddr) ||
                             (want_wr && z80fi_mem_waddr != sel_mem_waddr);
        mis_now[mis_wdata] = want_wr && z80fi_mem_wdata != sel_mem_wdata;
        if (!sel_valid)
            mis_now = 6'b0;
    end

    assign fail = z80fi_valid && ((|mis_now) || !sel_valid);

    always_ff @(posedge clock) begin
        if (reset) begin
            check_valid    <= 1'b0;
            check_ok       <= 1'b0;
            check_unknown  <= 1'b0;
            check_conflict <= 1'b0;
            mismatch       <= 6'b0;
            error_count    <= '0;
        end else begin
            check_valid    <= z80fi_valid;
            check_ok       <= z80fi_valid && sel_valid && mis_now == 6'b0;
            check_unknown  <= z80fi_valid && unknown;
            check_conflict <= z80fi_valid && sel_conflict;
            mismatch       <= z80fi_valid ? mis_now : 6'b0;
            if (fail && error_count != {err_count_width{1'b1}})
                error_count <= error_count + 1'b1; // Saturates.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/z80fi_spec_select.sv ====
// Spec selector.
// Merges the spec units into one set and flags no match or several.

`timescale 1ns/1ps
`default_nettype none

module z80fi_spec_select (
    input  logic        shift_valid, rot_valid, bit_valid,
    input  logic [3:0]  shift_signals, rot_signals, bit_signals,
    input  logic [15:0] shift_mem_raddr, rot_mem_raddr, bit_mem_raddr,
    input  logic [15:0] shift_mem_waddr, rot_mem_waddr, bit_mem_waddr,
    input  logic [7:0]  shift_mem_wdata, rot_mem_wdata, bit_mem_wdata,
    input  logic [7:0]  shift_reg_f_out, rot_reg_f_out, bit_reg_f_out,
    input  logic [15:0] shift_reg_ip_out, rot_reg_ip_out, bit_reg_ip_out,
    output logic        sel_valid,
    output logic        sel_conflict,
    output logic [3:0]  sel_signals,
    output logic [15:0] sel_mem_raddr,
    output logic [15:0] sel_mem_waddr,
    output logic [7:0]  sel_mem_wdata,
    output logic [7:0]  sel_reg_f_out,
    output logic [15:0] sel_reg_ip_out
);

    logic [1:0] match_count;

    assign match_count  = 2'(shift_valid) + 2'(rot_valid) + 2'(bit_valid);
    assign sel_valid    = (match_count == 2'd1);
    assign sel_conflict = (match_count > 2'd1);

    // Units that did not match contribute zeros.
    assign sel_signals = ({4{shift_valid}} & shift_signals) |
        ({4{rot_valid}} & rot_signals) | ({4{bit_valid}} & bit_signals);
    assign sel_mem_raddr = ({16{shift_valid}} & shift_mem_raddr) |
        ({16{rot_valid}} & rot_mem_raddr) | ({16{bit_valid}} & bit_mem_raddr);
    assign sel_mem_waddr = ({16{shift_valid}} & shift_mem_waddr) |
        ({16{rot_valid}} & rot_mem_waddr) | ({16{bit_valid}} & bit_mem_waddr);
    assign sel_mem_wdata = ({8{shift_valid}} & shift_mem_wdata) |
        ({8{rot_valid}} & rot_mem_wdata) | ({8{bit_valid}} & bit_mem_wdata);
    assign sel_reg_f_out = ({8{shift_valid}} & shift_reg_f_out) |
        ({8{rot_valid}} & rot_reg_f_out) | ({8{bit_valid}} & bit_reg_f_out);
    assign sel_reg_ip_out = ({16{shift_valid}} & shift_reg_ip_out) |
        ({16{rot_valid}} & rot_reg_ip_out) | ({16{bit_valid}} & bit_reg_ip_out);

endmodule

`default_nettype wire

// ==== hdl/z80fi_insn_spec_bit_idx_ixiy.sv ====
// BIT/SET/RES b,(IX/IY+d) spec.
// BIT tests a bit of the byte; SET and RES write it back modified.

`timescale 1ns/1ps
`default_nettype none

module z80fi_insn_spec_bit_idx_ixiy (
    input  logic        z80fi_valid,
    input  logic [31:0] z80fi_insn,
    input  logic [2:0]  z80fi_insn_len,
    input  logic [15:0] z80fi_reg_ip_in,
    input  logic [7:0]  z80fi_reg_f_in,
    input  logic [15:0] z80fi_reg_ix_in,
    input  logic [15:0] z80fi_reg_iy_in,
    input  logic [7:0]  z80fi_mem_rdata,
    output logic        spec_valid,
    output logic [3:0]  spec_signals,
    output logic [15:0] spec_mem_raddr,
    output logic [15:0] spec_mem_waddr,
    output logic [7:0]  spec_mem_wdata,
    output logic [7:0]  spec_reg_f_out,
    output logic [15:0] spec_reg_ip_out
);
    import z80fi_pkg::*;

    logic [7:0]  op, d, prefix, bit_mask;
    logic [2:0]  b;
    logic        is_bit, is_set, tested;
    logic [15:0] addr;

    assign op       = z80fi_insn[insn_op_lsb +: 8];
    assign d        = z80fi_insn[insn_d_lsb +: 8];
    assign prefix   = z80fi_insn[insn_prefix_lsb +: 8];
    assign b        = op[5:3];
    assign is_bit   = (op[7:6] == 2'b01);
    assign is_set   = (op[7:6] == 2'b11);
    assign bit_mask = 8'b0000_0001 << b;
    assign tested   = z80fi_mem_rdata[b];

    assign spec_valid = z80fi_valid && z80fi_insn_len == insn_len_idx_cb &&
        op[7:6] != 2'b00 && op[2:0] == 3'b110 &&
        z80fi_insn[insn_cb_lsb +: 8] == prefix_cb &&
        prefix[7:6] == prefix_ix_iy_mask_pattern[7:6] &&
        prefix[4:0] == prefix_ix_iy_mask_pattern[4:0];

    // BIT defines F but writes nothing; SET/RES write but leave F open.
    assign spec_signals = (4'b0001 << spec_reg_ip) | (4'b0001 << spec_mem_rd) |
        (is_bit ? (4'b0001 << spec_reg_f) : (4'b0001 << spec_mem_wr));

    assign addr = (z80fi_insn[insn_iy_bit] ? z80fi_reg_iy_in : z80fi_reg_ix_in) +
        {{8{d[7]}}, d};

    always_comb begin
        spec_reg_f_out             = z80fi_reg_f_in; // C kept.
        spec_reg_f_out[flag_s_num] = (b == 3'd7) && tested;
        spec_reg_f_out[flag_z_num] = !tested;
        spec_reg_f_out[flag_5_num] = addr[13]; // Leaks from the address.
        spec_reg_f_out[flag_h_num] = 1'b1;
        spec_reg_f_out[flag_3_num] = addr[11];
        spec_reg_f_out[flag_v_num] = !tested;
        spec_reg_f_out[flag_n_num] = 1'b0;
    end

    assign spec_mem_raddr  = addr;
    assign spec_mem_waddr  = addr;
    assign spec_mem_wdata  = is_set ? (z80fi_mem_rdata | bit_mask) :
                                      (z80fi_mem_rdata & ~bit_mask);
    assign spec_reg_ip_out = z80fi_reg_ip_in + 16'd4;

endmodule

`default_nettype wire

// ==== hdl/z80fi_insn_spec_rot_idx_ixiy.sv ====
// RLC/RRC/RL/RR (IX/IY+d) spec.
// Rotates the byte at IX/IY+d, circular or through carry.

`timescale 1ns/1ps
`default_nettype none

module z80fi_insn_spec_rot_idx_ixiy (
    input  logic        z80fi_valid,
    input  logic [31:0] z80fi_insn,
    input  logic [2:0]  z80fi_insn_len,
    input  logic [15:0] z80fi_reg_ip_in,
    input  logic [7:0]  z80fi_reg_f_in,
    input  logic [15:0] z80fi_reg_ix_in,
    input  logic [15:0] z80fi_reg_iy_in,
    input  logic [7:0]  z80fi_mem_rdata,
    output logic        spec_valid,
    output logic [3:0]  spec_signals,
    output logic [15:0] spec_mem_raddr,
    output logic [15:0] spec_mem_waddr,
    output logic [7:0]  spec_mem_wdata,
    output logic [7:0]  spec_reg_f_out,
    output logic [15:0] spec_reg_ip_out
);
    import z80fi_pkg::*;

    logic [7:0]  op, d, prefix, result;
    logic        thru_carry, right, fill;
    logic [15:0] addr;

    assign op         = z80fi_insn[insn_op_lsb +: 8];
    assign d          = z80fi_insn[insn_d_lsb +: 8];
    assign prefix     = z80fi_insn[insn_prefix_lsb +: 8];
    assign thru_carry = op[4]; // RL/RR.
    assign right      = op[3];

    assign spec_valid = z80fi_valid && z80fi_insn_len == insn_len_idx_cb &&
        op[7:5] == 3'b000 && op[2:0] == 3'b110 &&
        z80fi_insn[insn_cb_lsb +: 8] == prefix_cb &&
        prefix[7:6] == prefix_ix_iy_mask_pattern[7:6] &&
        prefix[4:0] == prefix_ix_iy_mask_pattern[4:0];

    assign spec_signals = (4'b0001 << spec_reg_ip) | (4'b0001 << spec_reg_f) |
        (4'b0001 << spec_mem_rd) | (4'b0001 << spec_mem_wr);

    // Fill bit comes from carry, or else wraps from the other end.
    always_comb begin
        if (thru_carry)
            fill = z80fi_reg_f_in[flag_c_num];
        else
            fill = right ? z80fi_mem_rdata[0] : z80fi_mem_rdata[7];
    end

    assign result = right ? {fill, z80fi_mem_rdata[7:1]} : {z80fi_mem_rdata[6:0], fill};

    always_comb begin
        spec_reg_f_out             = z80fi_reg_f_in;
        spec_reg_f_out[flag_s_num] = result[7];
        spec_reg_f_out[flag_z_num] = (result == 8'h00);
        spec_reg_f_out[flag_h_num] = 1'b0;
        spec_reg_f_out[flag_v_num] = parity8(result);
        spec_reg_f_out[flag_n_num] = 1'b0;
        spec_reg_f_out[flag_c_num] = right ? z80fi_mem_rdata[0] : z80fi_mem_rdata[7];
    end

    assign addr = (z80fi_insn[insn_iy_bit] ? z80fi_reg_iy_in : z80fi_reg_ix_in) +
        {{8{d[7]}}, d};
    assign spec_mem_raddr  = addr;
    assign spec_mem_waddr  = addr;
    assign spec_mem_wdata  = result;
    assign spec_reg_ip_out = z80fi_reg_ip_in + 16'd4;

endmodule

`default_nettype wire

// ==== hdl/z80fi_insn_spec_shift_idx_ixiy.sv ====
// SLA/SRA/SRL (IX/IY+d) spec.
// Shifts the byte at IX/IY+d left or right, arithmetic or logical.

`timescale 1ns/1ps
`default_nettype none

module z80fi_insn_spec_shift_idx_ixiy (
    input  logic        z80fi_valid,
    input  logic [31:0] z80fi_insn,
    input  logic [2:0]  z80fi_insn_len,
    input  logic [15:0] z80fi_reg_ip_in,
    input  logic [7:0]  z80fi_reg_f_in,
    input  logic [15:0] z80fi_reg_ix_in,
    input  logic [15:0] z80fi_reg_iy_in,
    input  logic [7:0]  z80fi_mem_rdata,
    output logic        spec_valid,
    output logic [3:0]  spec_signals,
    output logic [15:0] spec_mem_raddr,
    output logic [15:0] spec_mem_waddr,
    output logic [7:0]  spec_mem_wdata,
    output logic [7:0]  spec_reg_f_out,
    output logic [15:0] spec_reg_ip_out
);
    import z80fi_pkg::*;

    logic [7:0]  op, d, prefix, result;
    logic        logical, right, fill;
    logic [15:0] addr;

    assign op      = z80fi_insn[insn_op_lsb +: 8];
    assign d       = z80fi_insn[insn_d_lsb +: 8];
    assign prefix  = z80fi_insn[insn_prefix_lsb +: 8];
    assign logical = op[4];
    assign right   = op[3];

    assign spec_valid = z80fi_valid && z80fi_insn_len == insn_len_idx_cb &&
        op[7:5] == 3'b001 && op[2:0] == 3'b110 &&
        z80fi_insn[insn_cb_lsb +: 8] == prefix_cb &&
        prefix[7:6] == prefix_ix_iy_mask_pattern[7:6] &&
        prefix[4:0] == prefix_ix_iy_mask_pattern[4:0] &&
        !(logical && !right); // SLL is rejected.

    assign spec_signals = (4'b0001 << spec_reg_ip) | (4'b0001 << spec_reg_f) |
        (4'b0001 << spec_mem_rd) | (4'b0001 << spec_mem_wr);

    assign fill   = (!logical && right) ? z80fi_mem_rdata[7] : 1'b0; // SRA keeps sign.
    assign result = right ? {fill, z80fi_mem_rdata[7:1]} : {z80fi_mem_rdata[6:0], fill};

    always_comb begin
        spec_reg_f_out             = z80fi_reg_f_in; // Bits 5 and 3 kept.
        spec_reg_f_out[flag_s_num] = result[7];
        spec_reg_f_out[flag_z_num] = (result == 8'h00);
        spec_reg_f_out[flag_h_num] = 1'b0;
        spec_reg_f_out[flag_v_num] = parity8(result);
        spec_reg_f_out[flag_n_num] = 1'b0;
        spec_reg_f_out[flag_c_num] = right ? z80fi_mem_rdata[0] : z80fi_mem_rdata[7];
    end

    assign addr = (z80fi_insn[insn_iy_bit] ? z80fi_reg_iy_in : z80fi_reg_ix_in) +
        {{8{d[7]}}, d};
    assign spec_mem_raddr  = addr;
    assign spec_mem_waddr  = addr;
    assign spec_mem_wdata  = result;
    assign spec_reg_ip_out = z80fi_reg_ip_in + 16'd4;

endmodule

`default_nettype wire

// ==== hdl/z80fi_pkg.sv ====
// Z80 formal interface definitions for the indexed CB group checker.
// Instruction field positions, flag numbers, spec and mismatch bits.

`default_nettype none

package z80fi_pkg;

    localparam logic [2:0] insn_len_idx_cb = 3'd4; // DD/FD CB d op.

    // Byte lanes of the 32-bit instruction word.
    localparam int insn_op_lsb     = 24;
    localparam int insn_d_lsb      = 16;
    localparam int insn_cb_lsb     = 8;
    localparam int insn_prefix_lsb = 0;
    localparam int insn_iy_bit     = 5; // Set for FD.

    localparam logic [7:0] prefix_cb                 = 8'hCB;
    localparam logic [7:0] prefix_ix_iy_mask_pattern = 8'b11011101; // Bit 5 free.

    localparam logic [2:0] flag_s_num = 3'd7;
    localparam logic [2:0] flag_z_num = 3'd6;
    localparam logic [2:0] flag_5_num = 3'd5;
    localparam logic [2:0] flag_h_num = 3'd4;
    localparam logic [2:0] flag_3_num = 3'd3;
    localparam logic [2:0] flag_v_num = 3'd2;
    localparam logic [2:0] flag_n_num = 3'd1;
    localparam logic [2:0] flag_c_num = 3'd0;

    // Results an instruction defines.
    localparam logic [1:0] spec_reg_ip = 2'd0;
    localparam logic [1:0] spec_reg_f  = 2'd1;
    localparam logic [1:0] spec_mem_rd = 2'd2;
    localparam logic [1:0] spec_mem_wr = 2'd3;

    localparam logic [2:0] mis_ip    = 3'd0;
    localparam logic [2:0] mis_f     = 3'd1;
    localparam logic [2:0] mis_rd    = 3'd2;
    localparam logic [2:0] mis_wr    = 3'd3;
    localparam logic [2:0] mis_addr  = 3'd4;
    localparam logic [2:0] mis_wdata = 3'd5;

    localparam int err_count_width = 16;

    // One on even parity, as the Z80 P/V flag.
    function automatic logic parity8(input logic [7:0] b);
        return ~^b;
    endfunction

endpackage

`default_nettype wire
